/* dv/clk_gen.sv */
`default_nettype none

module clk_gen (
	output logic clk_125,
	output logic rst_crc
);

	localparam int HALF_PERIOD = 2;  // 4 time units per cycle
	localparam int RST_CYCLES  = 16;

	initial
	begin
		clk_125 = 1'b0;
		forever #HALF_PERIOD clk_125 = ~clk_125;
	end

	initial
	begin
		rst_crc = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_125);
		@(negedge clk_125);
		rst_crc = 1'b0;  // released away from the active edge
	end

endmodule

`default_nettype wire

/* dv/eth_stream_chk.sv */
`default_nettype none
`include "eth_stream_defs.svh"

module eth_stream_chk (
	input wire                           clk_125,
	input wire                           rst_crc,
	input wire                           tx_rdy,
	input wire eth_stream_pkg::tx_beat_t tx,
	input wire                           start,
	input wire                           end_tx
);

	localparam int FRAME_BEATS = `BUF_WORDS + 5;  // 4 header words, data, sum

	logic in_frame;        // between sop and eop
	logic busy;            // between start and end_tx
	logic [7:0] beat_cnt;  // accepted beats since start

	// ------------------------------
	// frame tracking
	// ------------------------------
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			in_frame <= 1'b0;
			busy     <= 1'b0;
			beat_cnt <= '0;
		end
		else
		begin
			if (tx.wren & tx.eop)
				in_frame <= 1'b0;
			else if (tx.wren & tx.sop)
				in_frame <= 1'b1;
			if (start)
			begin
				busy     <= 1'b1;
				beat_cnt <= '0;  // new frame
			end
			else if (end_tx)
				busy <= 1'b0;
			else if (busy & tx.wren)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// ------------------------------
	// beat protocol
	// ------------------------------
	a_wren_rdy: assert property (@(posedge clk_125) disable iff (rst_crc)
		tx.wren |-> tx_rdy)
		else $error("beat written while mac not ready");

	a_marks_wren: assert property (@(posedge clk_125) disable iff (rst_crc)
		(tx.sop | tx.eop) |-> tx.wren)
		else $error("sop or eop without wren");

	a_sop_once: assert property (@(posedge clk_125) disable iff (rst_crc)
		(tx.wren & tx.sop) |-> !in_frame)
		else $error("second sop before eop");

	a_beats_bounded: assert property (@(posedge clk_125) disable iff (rst_crc)
		busy |-> (beat_cnt <= 8'(FRAME_BEATS)))
		else $error("frame longer than its fixed beat count");

	a_end_after_last: assert property (@(posedge clk_125) disable iff (rst_crc)
		(busy && beat_cnt == 8'(FRAME_BEATS)) |-> end_tx)
		else $error("end_tx missing after last beat");

	a_end_count: assert property (@(posedge clk_125) disable iff (rst_crc)
		end_tx |-> (busy && beat_cnt == 8'(FRAME_BEATS)))
		else $error("end_tx with wrong beat count");

endmodule

`default_nettype wire

/* dv/eth_stream_tb.sv */
`default_nettype none
`include "eth_stream_defs.svh"

module eth_stream_tb;

	localparam int FRAME_BEATS = `BUF_WORDS + 5;  // ports, ip, tag, chan, data, sum
	localparam int N_FRAMES    = 10;              // frames over all behaviors
	localparam int TIMEOUT     = 20 * (FRAME_BEATS + 40) + 4 * `RESTART_HOLD;

	typedef struct packed {
		eth_stream_pkg::chan_t     channel;
		eth_stream_pkg::pkt_num_t  pkt_num;
		eth_stream_pkg::interval_t interval;
	} frame_exp_t;

	logic                        clk_125;
	logic                        rst_crc;
	eth_stream_pkg::word_t       data_ch0;
	eth_stream_pkg::word_t       data_ch1;
	logic                        wr_ch0;
	logic                        wr_ch1;
	eth_stream_pkg::interval_t   interval_num;
	logic                        time_clr;
	logic                        stream_stop;
	eth_stream_pkg::stream_cfg_t cfg;
	logic                        tx_rdy;
	eth_stream_pkg::tx_beat_t    tx;

	integer seed        = 32'ha2ba_0de6;
	int     cycle_cnt   = 0;
	int     frames_done = 0;
	int     beat_idx    = 0;       // position inside current frame
	int     fall_cycle;            // time_clr release
	logic   rand_rdy;              // mac stalls on
	logic   no_sop_win;            // restart window, sop forbidden
	eth_stream_pkg::pkt_num_t pkt_model;
	eth_stream_pkg::word_t    exp_word;
	eth_stream_pkg::word_t    blk [`BUF_WORDS];  // block of current frame
	eth_stream_pkg::word_t    q_ch0 [$];         // words that must come out
	eth_stream_pkg::word_t    q_ch1 [$];
	frame_exp_t               exp_q [$];         // frames in expected order
	frame_exp_t               cur;

	clk_gen i_clk_gen (
		.clk_125 (clk_125),
		.rst_crc (rst_crc)
	);

	eth_stream_top i_eth_stream_top (
		.clk_125      (clk_125),
		.rst_crc      (rst_crc),
		.data_ch0     (data_ch0),
		.data_ch1     (data_ch1),
		.wr_ch0       (wr_ch0),
		.wr_ch1       (wr_ch1),
		.interval_num (interval_num),
		.time_clr     (time_clr),
		.stream_stop  (stream_stop),
		.cfg          (cfg),
		.tx_rdy       (tx_rdy),
		.tx           (tx)
	);

	bind udp_frame_sender eth_stream_chk i_eth_stream_chk (
		.clk_125 (clk_125),
		.rst_crc (rst_crc),
		.tx_rdy  (tx_rdy),
		.tx      (tx),
		.start   (start),
		.end_tx  (end_tx)
	);

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	// expected word idx of a frame, block taken from blk
	function automatic eth_stream_pkg::word_t ref_word(input int idx, input frame_exp_t fe);
		eth_stream_pkg::byte_len_t port_data;
		eth_stream_pkg::byte_len_t nbytes;
		eth_stream_pkg::word_t     sum;
		port_data = cfg.port_dest + 16'd1;  // data port sits above control port
		nbytes    = 16'(`BUF_WORDS * 4);
		sum       = '0;
		for (int i = 0; i < `BUF_WORDS; i++)
			sum = sum + blk[i];  // wraps mod 2^32
		if (idx == 0)
			return {cfg.port_src, port_data};
		else if (idx == 1)
			return cfg.ip_dest;
		else if (idx == 2)
			return {fe.interval, fe.pkt_num};  // time tag
		else if (idx == 3)
			return {eth_stream_pkg::byte_len_t'(fe.channel), nbytes};
		else if (idx < 4 + `BUF_WORDS)
			return blk[idx - 4];
		else
			return sum;
	endfunction

	// ------------------------------
	// compare and timeout
	// ------------------------------
	always @(posedge clk_125)
	begin
		if (!rst_crc)
		begin
			if (no_sop_win)
				assert (!tx.sop) else fail_now("sop appeared inside the restart holdoff");
			if (tx.wren)
			begin
				assert (tx_rdy) else fail_now("beat accepted while tx_rdy was low");
				if (beat_idx == 0)
				begin
					assert (exp_q.size() != 0) else fail_now("frame sent when none was expected");
					cur = exp_q.pop_front();
					assert ((cur.channel == 0 ? q_ch0.size() : q_ch1.size()) >= `BUF_WORDS)
					else fail_now("frame started before a full block was written");
					for (int i = 0; i < `BUF_WORDS; i++)
						blk[i] = (cur.channel == 0) ? q_ch0.pop_front() : q_ch1.pop_front();
				end
				exp_word = ref_word(beat_idx, cur);
				assert (tx.data == exp_word)
				else fail_now($sformatf("error: tx.data beat %0d expected %h actual %h",
					beat_idx, exp_word, tx.data));
				assert (tx.sop == (beat_idx == 0))
				else fail_now($sformatf("error: tx.sop beat %0d expected %h actual %h",
					beat_idx, beat_idx == 0, tx.sop));
				assert (tx.eop == (beat_idx == FRAME_BEATS - 1))
				else fail_now($sformatf("error: tx.eop beat %0d expected %h actual %h",
					beat_idx, beat_idx == FRAME_BEATS - 1, tx.eop));
				if (beat_idx == FRAME_BEATS - 1)
				begin
					beat_idx    = 0;
					frames_done = frames_done + 1;
				end
				else
					beat_idx = beat_idx + 1;
			end
		end
	end

	always @(posedge clk_125)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT)
			fail_now($sformatf("timeout after %0d cycles with %0d of %0d frames seen",
				cycle_cnt, frames_done, N_FRAMES));
	end

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	task automatic next_cycle();
		integer rnd;
		@(negedge clk_125);
		if (rand_rdy)
		begin
			rnd    = $random(seed);
			tx_rdy = rnd[0];  // about half the cycles stalled
		end
		else
			tx_rdy = 1'b1;
	endtask

	task automatic write_words(input int n0, input int n1, input bit keep);
		for (int i = 0; i < n0 || i < n1; i++)
		begin
			next_cycle();
			wr_ch0   = (i < n0);
			wr_ch1   = (i < n1);
			data_ch0 = $random(seed);
			data_ch1 = $random(seed);
			if (keep && i < n0)
				q_ch0.push_back(data_ch0);
			if (keep && i < n1)
				q_ch1.push_back(data_ch1);
		end
		next_cycle();
		wr_ch0 = 1'b0;
		wr_ch1 = 1'b0;
	endtask

	task automatic expect_frame(input int ch);
		frame_exp_t fe;
		fe.channel  = eth_stream_pkg::chan_t'(ch);
		fe.pkt_num  = pkt_model;
		fe.interval = interval_num;
		exp_q.push_back(fe);
		pkt_model = pkt_model + 1'b1;
	endtask

	task automatic wait_frames(input int n);
		while (frames_done < n)
			next_cycle();  // bounded by the timeout
	endtask

	task automatic check_quiet(input int n);
		repeat (n)
		begin
			@(posedge clk_125);
			assert (!tx.wren && !tx.sop && !tx.eop)
			else fail_now("tx beat seen before any data was written");
		end
	endtask

	initial
	begin
		data_ch0      = '0;
		data_ch1      = '0;
		wr_ch0        = 1'b0;
		wr_ch1        = 1'b0;
		interval_num  = 16'h0001;
		time_clr      = 1'b0;
		stream_stop   = 1'b0;
		tx_rdy        = 1'b1;
		cfg.port_src  = 16'h1f90;
		cfg.port_dest = 16'h2710;
		cfg.ip_dest   = 32'hc0a8_0142;
		rand_rdy      = 1'b0;
		no_sop_win    = 1'b0;
		pkt_model     = '0;
		wait (rst_crc === 1'b0);
		next_cycle();

		check_quiet(50);  // idle after reset

		expect_frame(0);  // single block on ch0, pkt 0
		write_words(`BUF_WORDS, 0, 1'b1);
		wait_frames(1);

		// ------------------------------
		// both channels, alternating
		// ------------------------------
		interval_num = 16'h0101;
		expect_frame(1);  // ch0 served last
		expect_frame(0);
		write_words(`BUF_WORDS, `BUF_WORDS, 1'b1);
		wait_frames(3);
		interval_num = 16'h0102;
		expect_frame(1);
		expect_frame(0);
		write_words(`BUF_WORDS, `BUF_WORDS, 1'b1);
		wait_frames(5);

		rand_rdy     = 1'b1;  // mac back-pressure
		interval_num = 16'h0103;
		expect_frame(1);
		expect_frame(0);
		write_words(`BUF_WORDS, `BUF_WORDS, 1'b1);
		wait_frames(7);
		rand_rdy = 1'b0;

		// ------------------------------
		// time clear and holdoff
		// ------------------------------
		write_words(10, 0, 1'b0);  // partial block, flushed by clear
		no_sop_win = 1'b1;
		time_clr   = 1'b1;
		repeat (4) next_cycle();
		time_clr   = 1'b0;
		fall_cycle = cycle_cnt;
		write_words(0, 20, 1'b0);  // lands in holdoff, dropped
		while (cycle_cnt < fall_cycle + `RESTART_HOLD)
			next_cycle();
		no_sop_win = 1'b0;
		repeat (10) next_cycle();
		pkt_model    = '0;  // count restarts with the interval
		interval_num = 16'h0200;
		expect_frame(0);
		write_words(`BUF_WORDS, 0, 1'b1);
		wait_frames(8);

		stream_stop = 1'b1;  // fifos held clear, writes overflow depth
		no_sop_win  = 1'b1;
		write_words(`FIFO_DEPTH + 6, `FIFO_DEPTH + 6, 1'b0);
		stream_stop = 1'b0;
		repeat (`RESTART_HOLD + 10) next_cycle();
		no_sop_win   = 1'b0;
		interval_num = 16'h0300;
		expect_frame(1);  // stop leaves pkt count running
		expect_frame(0);
		write_words(`BUF_WORDS, `BUF_WORDS, 1'b1);
		wait_frames(N_FRAMES);

		repeat (20) next_cycle();  // catch any late extra frame
		if (exp_q.size() == 0 && q_ch0.size() == 0 && q_ch1.size() == 0
			&& frames_done == N_FRAMES)
		begin
			$display("all tests passed");
			$finish;
		end
		else
			fail_now($sformatf("run ended with %0d frames, %0d pending, %0d/%0d words unsent",
				frames_done, exp_q.size(), q_ch0.size(), q_ch1.size()));
	end

endmodule

`default_nettype wire

/* eth_stream.f */
+incdir+hdl
hdl/eth_stream_pkg.sv
hdl/chan_fifo.sv
hdl/restart_ctrl.sv
hdl/buffer_former.sv
hdl/udp_frame_sender.sv
hdl/eth_stream_top.sv
dv/clk_gen.sv
dv/eth_stream_chk.sv
dv/eth_stream_tb.sv

/* hdl/buffer_former.sv */
`default_nettype none
`include "eth_stream_defs.svh"

module buffer_former (
	input  wire                              clk_125,
	input  wire                              rst_crc,
	input  wire                              hold,          // restart in progress
	input  wire                              tag_clr,
	input  wire eth_stream_pkg::interval_t   interval_num,
	input  wire [`FIFO_LVL_W-1:0]            level0,
	input  wire [`FIFO_LVL_W-1:0]            level1,
	input  wire eth_stream_pkg::word_t       fifo_data0,
	input  wire eth_stream_pkg::word_t       fifo_data1,
	output logic                             rd0,
	output logic                             rd1,
	input  wire                              end_tx,
	output logic                             start,
	output eth_stream_pkg::buf_desc_t        desc,
	input  wire eth_stream_pkg::buf_addr_t   buf_rd_addr,
	output eth_stream_pkg::word_t            buf_rd_data
);

	localparam int SEL_W = $clog2(`N_CHAN);

	eth_stream_pkg::former_state_t state;
	eth_stream_pkg::word_t ram [`BUF_WORDS];  // one block
	eth_stream_pkg::word_t rd_data;
	eth_stream_pkg::word_t sum;
	eth_stream_pkg::word_t sum_next;
	eth_stream_pkg::buf_addr_t wr_addr;
	eth_stream_pkg::buf_addr_t rd_cnt;
	eth_stream_pkg::pkt_num_t pkt_cnt;
	logic [SEL_W-1:0] sel;  // current / last served channel
	logic rd_vld;           // fifo data present this clk
	logic rdy0;
	logic rdy1;
	logic pick1;

	assign rdy0  = (level0 >= `BUF_WORDS);
	assign rdy1  = (level1 >= `BUF_WORDS);
	assign pick1 = rdy1 & (~rdy0 | (sel == '0));  // round robin when both ready

	assign rd0 = (state == eth_stream_pkg::F_READ) & ~hold & (sel == '0);
	assign rd1 = (state == eth_stream_pkg::F_READ) & ~hold & (sel != '0);

	assign rd_data  = (sel == '0) ? fifo_data0 : fifo_data1;
	assign sum_next = sum + rd_data;  // wraps mod 2^32

	// ------------------------------
	// control fsm
	// ------------------------------
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			state   <= eth_stream_pkg::F_IDLE;
			sel     <= '1;  // ch0 goes first
			start   <= 1'b0;
			rd_vld  <= 1'b0;
			rd_cnt  <= '0;
			pkt_cnt <= '0;
		end
		else
		begin
			start  <= 1'b0;
			rd_vld <= (state == eth_stream_pkg::F_READ) & ~hold;
			if (hold)
				state <= eth_stream_pkg::F_IDLE;
			else
				case (state)
					eth_stream_pkg::F_IDLE:
						if (rdy0 | rdy1)
						begin
							sel    <= SEL_W'(pick1);
							rd_cnt <= '0;
							state  <= eth_stream_pkg::F_READ;
						end
					eth_stream_pkg::F_READ:
					begin
						rd_cnt <= rd_cnt + 1'b1;
						if (rd_cnt == `BUF_WORDS - 1)
							state <= eth_stream_pkg::F_DONE;  // last rd issued
					end
					eth_stream_pkg::F_DONE:
					begin
						start   <= 1'b1;
						pkt_cnt <= pkt_cnt + 1'b1;
						state   <= eth_stream_pkg::F_WAIT_TX;
					end
					eth_stream_pkg::F_WAIT_TX:
						if (end_tx)
							state <= eth_stream_pkg::F_IDLE;
					default:
						state <= eth_stream_pkg::F_IDLE;
				endcase
			if (tag_clr)
				pkt_cnt <= '0;  // new interval wins over increment
		end
	end

	// ------------------------------
	// buffer ram, sum and descriptor
	// ------------------------------
	always_ff @(posedge clk_125)
	begin
		if (state == eth_stream_pkg::F_IDLE)
		begin
			wr_addr <= '0;
			sum     <= '0;
		end
		else if (rd_vld)
		begin
			ram[wr_addr] <= rd_data;
			wr_addr      <= wr_addr + 1'b1;
			sum          <= sum_next;
		end
		if (state == eth_stream_pkg::F_DONE)
		begin
			// last word lands this clk, so take sum_next
			desc.channel  <= eth_stream_pkg::chan_t'(sel);
			desc.nbytes   <= eth_stream_pkg::byte_len_t'(`BUF_WORDS * 4);
			desc.sum      <= sum_next;
			desc.interval <= interval_num;
			desc.pkt_num  <= pkt_cnt;
		end
		buf_rd_data <= ram[buf_rd_addr];  // sender read port
	end

endmodule

`default_nettype wire

/* hdl/chan_fifo.sv */
`default_nettype none
`include "eth_stream_defs.svh"

module chan_fifo (
	input  wire                         clk_125,
	input  wire                         rst_crc,
	input  wire                         clr,    // level, held during restart
	input  wire                         wr,
	input  wire eth_stream_pkg::word_t  wdata,
	input  wire                         rd,
	output eth_stream_pkg::word_t       rdata,  // valid 1 clk after rd
	output logic [`FIFO_LVL_W-1:0]      level,
	output logic                        full
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);

	eth_stream_pkg::word_t mem [`FIFO_DEPTH];  // circular storage
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign full  = (level == `FIFO_DEPTH);
	assign do_wr = wr & ~full & ~clr;          // write on full is lost
	assign do_rd = rd & (level != '0) & ~clr;  // no underflow

	always_ff @(posedge clk_125)
	begin
		if (rst_crc | clr)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;  // flush everything
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;  // both or none
			endcase
		end
	end

	always_ff @(posedge clk_125)
	begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
		if (do_rd)
			rdata <= mem[rd_ptr];  // registered read port
	end

endmodule

`default_nettype wire

/* hdl/eth_stream_defs.svh */
`ifndef ETH_STREAM_DEFS_SVH
`define ETH_STREAM_DEFS_SVH

// ------------------------------
// datapath sizes
// ------------------------------
`define WORD_W          32   // fifo and mac word
`define BUF_WORDS       16   // words per udp block
`define N_CHAN          2    // data channels

// ------------------------------
// channel fifo
// ------------------------------
`define FIFO_DEPTH      64   // words per channel
`define FIFO_LVL_W      7    // holds 0..FIFO_DEPTH

// ------------------------------
// restart control
// ------------------------------
`define RESTART_HOLD    100  // holdoff after clear or stop
`define CLR_SYNC_STAGES 3    // time_clr synchroniser depth

`endif

/* hdl/eth_stream_pkg.sv */
`default_nettype none
`include "eth_stream_defs.svh"

package eth_stream_pkg;

	typedef logic [`WORD_W-1:0] word_t;                    // fifo / mac word
	typedef logic [7:0] chan_t;                            // channel number
	typedef logic [15:0] byte_len_t;                       // byte count or udp port
	typedef logic [15:0] interval_t;                       // interval after second mark
	typedef logic [15:0] pkt_num_t;                        // packet within interval
	typedef logic [$clog2(`BUF_WORDS)-1:0] buf_addr_t;     // buffer ram address
	typedef logic [31:0] ip_addr_t;                        // ipv4

	typedef struct packed {
		byte_len_t port_src;   // our port
		byte_len_t port_dest;  // control port, data goes to +1
		ip_addr_t  ip_dest;
	} stream_cfg_t;

	typedef struct packed {
		chan_t     channel;
		byte_len_t nbytes;     // block length in bytes
		word_t     sum;        // mod 2^32 sum of block
		interval_t interval;
		pkt_num_t  pkt_num;
	} buf_desc_t;

	typedef struct packed {
		word_t data;
		logic  sop;
		logic  eop;
		logic  wren;
	} tx_beat_t;

	typedef enum logic [1:0] {F_IDLE, F_READ, F_DONE, F_WAIT_TX} former_state_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_HDR_PORTS,
		S_HDR_IP,
		S_HDR_TAG,
		S_HDR_CHAN,
		S_DATA,
		S_SUM
	} sender_state_t;

endpackage

`default_nettype wire

/* hdl/eth_stream_top.sv */
`default_nettype none
`include "eth_stream_defs.svh"

module eth_stream_top (
	input  wire                              clk_125,
	input  wire                              rst_crc,
	input  wire eth_stream_pkg::word_t       data_ch0,
	input  wire eth_stream_pkg::word_t       data_ch1,
	input  wire                              wr_ch0,
	input  wire                              wr_ch1,
	input  wire eth_stream_pkg::interval_t   interval_num,
	input  wire                              time_clr,
	input  wire                              stream_stop,
	input  wire eth_stream_pkg::stream_cfg_t cfg,
	input  wire                              tx_rdy,
	output eth_stream_pkg::tx_beat_t         tx
);

	logic former_hold;
	logic fifo_clr;
	logic tag_clr;
	logic rd0;
	logic rd1;
	logic start;
	logic end_tx;
	logic [`FIFO_LVL_W-1:0] level0;
	logic [`FIFO_LVL_W-1:0] level1;
	eth_stream_pkg::word_t fifo_data0;
	eth_stream_pkg::word_t fifo_data1;
	eth_stream_pkg::buf_desc_t desc;
	eth_stream_pkg::buf_addr_t buf_rd_addr;
	eth_stream_pkg::word_t buf_rd_data;

	restart_ctrl i_restart_ctrl (
		.clk_125     (clk_125),
		.rst_crc     (rst_crc),
		.time_clr    (time_clr),
		.stream_stop (stream_stop),
		.former_hold (former_hold),
		.fifo_clr    (fifo_clr),
		.tag_clr     (tag_clr)
	);

	// ------------------------------
	// channel fifos
	// ------------------------------
	chan_fifo i_fifo_ch0 (
		.clk_125 (clk_125),
		.rst_crc (rst_crc),
		.clr     (fifo_clr),
		.wr      (wr_ch0),
		.wdata   (data_ch0),
		.rd      (rd0),
		.rdata   (fifo_data0),
		.level   (level0),
		.full    ()
	);

	chan_fifo i_fifo_ch1 (
		.clk_125 (clk_125),
		.rst_crc (rst_crc),
		.clr     (fifo_clr),
		.wr      (wr_ch1),
		.wdata   (data_ch1),
		.rd      (rd1),
		.rdata   (fifo_data1),
		.level   (level1),
		.full    ()
	);

	buffer_former i_buffer_former (
		.clk_125      (clk_125),
		.rst_crc      (rst_crc),
		.hold         (former_hold),
		.tag_clr      (tag_clr),
		.interval_num (interval_num),
		.level0       (level0),
		.level1       (level1),
		.fifo_data0   (fifo_data0),
		.fifo_data1   (fifo_data1),
		.rd0          (rd0),
		.rd1          (rd1),
		.end_tx       (end_tx),
		.start        (start),
		.desc         (desc),
		.buf_rd_addr  (buf_rd_addr),
		.buf_rd_data  (buf_rd_data)
	);

	udp_frame_sender i_udp_frame_sender (
		.clk_125     (clk_125),
		.rst_crc     (rst_crc),
		.cfg         (cfg),
		.start       (start),
		.desc        (desc),
		.buf_rd_addr (buf_rd_addr),
		.buf_rd_data (buf_rd_data),
		.tx_rdy      (tx_rdy),
		.tx          (tx),
		.end_tx      (end_tx)
	);

endmodule

`default_nettype wire

/* hdl/restart_ctrl.sv */
`default_nettype none
`include "eth_stream_defs.svh"

module restart_ctrl (
	input  wire  clk_125,
	input  wire  rst_crc,
	input  wire  time_clr,     // async level from timing unit
	input  wire  stream_stop,  // control bit 0
	output logic former_hold,
	output logic fifo_clr,
	output logic tag_clr       // one clk on sync rise
);

	localparam int SYNC_N = `CLR_SYNC_STAGES;
	localparam int CNT_W  = $clog2(`RESTART_HOLD + 1);

	logic [SYNC_N:0] clr_sr;  // top bit is the edge detect stage
	logic cause;
	logic hold_q;
	logic [CNT_W-1:0] hold_cnt;

	// ------------------------------
	// time_clr synchroniser
	// ------------------------------
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
			clr_sr <= '0;
		else
			clr_sr <= {clr_sr[SYNC_N-1:0], time_clr};
	end

	assign tag_clr = clr_sr[SYNC_N-1] & ~clr_sr[SYNC_N];  // rise of sync level
	assign cause   = (|clr_sr) | stream_stop;             // any stage counts

	// ------------------------------
	// holdoff timer
	// ------------------------------
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			hold_q   <= 1'b0;
			hold_cnt <= '0;
		end
		else if (cause)
		begin
			hold_q   <= 1'b1;
			hold_cnt <= '0;  // restart count while cause stays
		end
		else if (hold_q)
		begin
			if (hold_cnt == CNT_W'(`RESTART_HOLD - 1))
				hold_q <= 1'b0;  // holdoff done
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

	assign former_hold = hold_q | cause;
	assign fifo_clr    = hold_q | cause;  // fifos flushed for the whole hold

endmodule

`default_nettype wire

/* hdl/udp_frame_sender.sv */
`default_nettype none
`include "eth_stream_defs.svh"

module udp_frame_sender (
	input  wire                              clk_125,
	input  wire                              rst_crc,
	input  wire eth_stream_pkg::stream_cfg_t cfg,
	input  wire                              start,
	input  wire eth_stream_pkg::buf_desc_t   desc,
	output eth_stream_pkg::buf_addr_t        buf_rd_addr,
	input  wire eth_stream_pkg::word_t       buf_rd_data,  // 1 clk after addr
	input  wire                              tx_rdy,
	output eth_stream_pkg::tx_beat_t         tx,
	output logic                             end_tx
);

	eth_stream_pkg::sender_state_t state;
	eth_stream_pkg::buf_desc_t desc_q;  // frozen for the frame
	eth_stream_pkg::buf_addr_t idx;     // word on the bus in S_DATA
	logic acc;                          // beat accepted

	assign acc = tx_rdy & (state != eth_stream_pkg::S_IDLE);

	// look one word ahead so data beats go back to back
	assign buf_rd_addr = (acc && state == eth_stream_pkg::S_DATA) ? idx + 1'b1 : idx;

	// ------------------------------
	// beat mux
	// ------------------------------
	always_comb
	begin
		tx.wren = acc;
		tx.sop  = acc & (state == eth_stream_pkg::S_HDR_PORTS);
		tx.eop  = acc & (state == eth_stream_pkg::S_SUM);
		case (state)
			eth_stream_pkg::S_HDR_PORTS:
				tx.data = {cfg.port_src, eth_stream_pkg::byte_len_t'(cfg.port_dest + 1'b1)};
			eth_stream_pkg::S_HDR_IP:
				tx.data = cfg.ip_dest;
			eth_stream_pkg::S_HDR_TAG:
				tx.data = {desc_q.interval, desc_q.pkt_num};  // time tag
			eth_stream_pkg::S_HDR_CHAN:
				tx.data = {8'd0, desc_q.channel, desc_q.nbytes};
			eth_stream_pkg::S_DATA:
				tx.data = buf_rd_data;
			eth_stream_pkg::S_SUM:
				tx.data = desc_q.sum;
			default:
				tx.data = '0;
		endcase
	end

	// ------------------------------
	// frame sequencer
	// ------------------------------
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			state  <= eth_stream_pkg::S_IDLE;
			idx    <= '0;
			end_tx <= 1'b0;
		end
		else
		begin
			end_tx <= acc & (state == eth_stream_pkg::S_SUM);  // after last beat
			case (state)
				eth_stream_pkg::S_IDLE:
				begin
					idx <= '0;
					if (start)
						state <= eth_stream_pkg::S_HDR_PORTS;
				end
				eth_stream_pkg::S_HDR_PORTS:
					if (tx_rdy)
						state <= eth_stream_pkg::S_HDR_IP;
				eth_stream_pkg::S_HDR_IP:
					if (tx_rdy)
						state <= eth_stream_pkg::S_HDR_TAG;
				eth_stream_pkg::S_HDR_TAG:
					if (tx_rdy)
						state <= eth_stream_pkg::S_HDR_CHAN;
				eth_stream_pkg::S_HDR_CHAN:
					if (tx_rdy)
						state <= eth_stream_pkg::S_DATA;
				eth_stream_pkg::S_DATA:
					if (tx_rdy)
					begin
						idx <= idx + 1'b1;
						if (idx == `BUF_WORDS - 1)
							state <= eth_stream_pkg::S_SUM;
					end
				eth_stream_pkg::S_SUM:
					if (tx_rdy)
						state <= eth_stream_pkg::S_IDLE;
				default:
					state <= eth_stream_pkg::S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_125)
	begin
		if (state == eth_stream_pkg::S_IDLE && start)
			desc_q <= desc;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the eth_stream testbench with verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f eth_stream.f --top-module eth_stream_tb \
	-Mdir "$obj_dir" -o eth_stream_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$obj_dir/eth_stream_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
fi

grep -Fxq "all tests passed" "$log_file"
if [ $? -eq 0 ]; then
	echo "result: pass"
	exit 0
fi
echo "result: fail"
exit 1
